//--- src/rx_consts.svh
// receive chain constants
// channel geometry, frame shape and buffer sizing
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

////////////////////////////////////////////////////////////
// channel geometry
////////////////////////////////////////////////////////////
`define RX_CHANNELS 2        // physical channels, same count of logical ones
`define RX_PAR_SAMPLES 4     // samples per channel per cycle
`define RX_SAMPLE_WIDTH 16   // bits per adc sample

////////////////////////////////////////////////////////////
// timestamp and storage
////////////////////////////////////////////////////////////
`define RX_TSTAMP_WIDTH 32   // frame counter width
`define RX_BUF_DEPTH 8       // kept frames held by the buffer fifo

// index into the mux sources
// must cover raw plus differentiated channels
`define RX_SRC_BITS 2

`endif

//--- src/rx_pkg.sv
// receive chain types
// frames, configuration words, fifo entries and dma records
`include "rx_consts.svh"

package rx_pkg;

  // sample containers
  typedef logic signed [`RX_SAMPLE_WIDTH-1:0] sample_t;  // one adc sample
  typedef sample_t [`RX_PAR_SAMPLES-1:0] chan_frame_t;   // one channel for one cycle
  typedef chan_frame_t [`RX_CHANNELS-1:0] adc_frame_t;   // every physical channel
  typedef chan_frame_t [2*`RX_CHANNELS-1:0] src_frame_t; // raw sources then differences

  // small index and mask types
  typedef logic [`RX_SRC_BITS-1:0] src_idx_t;
  typedef logic [$clog2(`RX_CHANNELS)-1:0] chan_idx_t;
  typedef logic [`RX_CHANNELS-1:0] chan_mask_t;          // one bit per logical channel
  typedef logic [`RX_TSTAMP_WIDTH-1:0] tstamp_t;

  // mux config, source index per logical channel
  typedef src_idx_t [`RX_CHANNELS-1:0] mux_cfg_t;

  // discriminator thresholds, signed
  typedef struct packed {
    sample_t [`RX_CHANNELS-1:0] high; // enter active above this
    sample_t [`RX_CHANNELS-1:0] low;  // leave active when all below this
  } disc_cfg_t;

  // one fifo entry
  typedef struct packed {
    adc_frame_t data;   // logical frame
    chan_mask_t mask;   // channels worth keeping
    tstamp_t    tstamp; // frame count at arrival
  } kept_frame_t;

  // one record on the dma stream
  typedef struct packed {
    chan_idx_t   chan;
    tstamp_t     tstamp;
    chan_frame_t samples;
  } dma_record_t;

  // hysteresis state of a logical channel
  typedef enum logic {
    IDLE   = 1'b0,
    ACTIVE = 1'b1
  } disc_state_t;

endpackage

//--- src/axis_differentiator.sv
// differentiator stage
// first difference of each channel across frame boundaries, plus aligned raw copy
`timescale 1ns/1ps
`include "rx_consts.svh"

module axis_differentiator (
  input  logic               clk,
  input  logic               arst_n,
  input  rx_pkg::adc_frame_t adc_data,
  input  logic               adc_valid,
  output rx_pkg::src_frame_t src_data,
  output logic               src_valid
);

  import rx_pkg::*;

  sample_t    prev_last [`RX_CHANNELS]; // last sample of previous valid frame
  adc_frame_t diff;                     // differences for this cycle

  ////////////////////////////////////////////////////////////
  // first difference
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int ch = 0; ch < `RX_CHANNELS; ch++) begin
      // sample 0 reaches back into the previous frame
      diff[ch][0] = adc_data[ch][0] - prev_last[ch];
      for (int k = 1; k < `RX_PAR_SAMPLES; k++) begin
        diff[ch][k] = adc_data[ch][k] - adc_data[ch][k-1]; // wraps at 16 bits
      end
    end
  end

  // history and valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_valid <= 1'b0;
      for (int ch = 0; ch < `RX_CHANNELS; ch++) begin
        prev_last[ch] <= '0; // first frame differences against zero
      end
    end else begin
      src_valid <= adc_valid;
      if (adc_valid) begin
        for (int ch = 0; ch < `RX_CHANNELS; ch++) begin
          prev_last[ch] <= adc_data[ch][`RX_PAR_SAMPLES-1];
        end
      end
      // history held while valid is low
    end
  end

  ////////////////////////////////////////////////////////////
  // source register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (adc_valid) begin
      for (int ch = 0; ch < `RX_CHANNELS; ch++) begin
        src_data[ch]              <= adc_data[ch]; // raw, same cycle as diff
        src_data[`RX_CHANNELS+ch] <= diff[ch];
      end
    end
  end

endmodule

//--- src/axis_channel_mux.sv
// channel mux stage
// maps raw and differentiated sources onto the logical channels
`timescale 1ns/1ps
`include "rx_consts.svh"

module axis_channel_mux (
  input  logic               clk,
  input  logic               arst_n,
  input  rx_pkg::src_frame_t src_data,
  input  logic               src_valid,
  input  rx_pkg::mux_cfg_t   mux_cfg,
  input  logic               mux_cfg_valid,
  output rx_pkg::adc_frame_t log_data,
  output logic               log_valid
);

  import rx_pkg::*;

  mux_cfg_t cfg_q; // active source selection

  ////////////////////////////////////////////////////////////
  // config register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // identity mapping, logical i reads raw channel i
      for (int i = 0; i < `RX_CHANNELS; i++) begin
        cfg_q[i] <= src_idx_t'(i);
      end
    end else if (mux_cfg_valid) begin
      cfg_q <= mux_cfg; // realtime, never refused
    end
  end

  // valid tracks the source by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      log_valid <= 1'b0;
    end else begin
      log_valid <= src_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // selection
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (src_valid) begin
      for (int i = 0; i < `RX_CHANNELS; i++) begin
        log_data[i] <= src_data[cfg_q[i]]; // old config if written this cycle
      end
    end
  end

  // every source frame produces exactly one logical frame a cycle later
  a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    log_valid == $past(src_valid));

endmodule

//--- src/sample_discriminator.sv
// sample discriminator stage
// per channel hysteresis against signed thresholds, stamps kept frames with the frame count
`timescale 1ns/1ps
`include "rx_consts.svh"

module sample_discriminator (
  input  logic                clk,
  input  logic                arst_n,
  input  rx_pkg::adc_frame_t  log_data,
  input  logic                log_valid,
  input  rx_pkg::disc_cfg_t   disc_cfg,
  input  logic                disc_cfg_valid,
  output rx_pkg::kept_frame_t kept,
  output logic                kept_valid
);

  import rx_pkg::*;

  disc_cfg_t   cfg_q;                   // latched thresholds
  disc_state_t state_q [`RX_CHANNELS];  // hysteresis state
  disc_state_t state_d [`RX_CHANNELS];
  tstamp_t     frame_cnt;               // counts every valid frame
  chan_mask_t  any_above;               // some sample above high
  chan_mask_t  all_below;               // every sample below low
  chan_mask_t  keep;

  ////////////////////////////////////////////////////////////
  // threshold compare and next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      any_above[c] = 1'b0;
      all_below[c] = 1'b1;
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) begin
        if (log_data[c][k] > cfg_q.high[c]) any_above[c] = 1'b1; // signed
        if (!(log_data[c][k] < cfg_q.low[c])) all_below[c] = 1'b0;
      end
      state_d[c] = state_q[c];
      keep[c]    = 1'b0;
      case (state_q[c])
        IDLE: begin
          if (any_above[c]) begin
            keep[c]    = 1'b1;
            state_d[c] = ACTIVE;
          end
        end
        ACTIVE: begin
          keep[c] = 1'b1; // closing frame is kept too
          if (all_below[c]) state_d[c] = IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // control state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_q      <= '0;
      frame_cnt  <= '0;
      kept_valid <= 1'b0;
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        state_q[c] <= IDLE;
      end
    end else begin
      if (disc_cfg_valid) cfg_q <= disc_cfg;
      kept_valid <= log_valid && (|keep); // empty masks never leave
      if (log_valid) begin
        frame_cnt <= frame_cnt + 1'b1;
        for (int c = 0; c < `RX_CHANNELS; c++) begin
          state_q[c] <= state_d[c];
        end
      end
    end
  end

  // kept frame payload
  always_ff @(posedge clk) begin
    if (log_valid) begin
      kept.data   <= log_data;
      kept.mask   <= keep;
      kept.tstamp <= frame_cnt; // first frame after reset is 0
    end
  end

endmodule

//--- src/sample_buffer.sv
// sample buffer stage
// fifo of kept frames, serialized into one dma record per kept channel
`timescale 1ns/1ps
`include "rx_consts.svh"

module sample_buffer (
  input  logic                clk,
  input  logic                arst_n,
  input  rx_pkg::kept_frame_t kept,
  input  logic                kept_valid,
  output rx_pkg::dma_record_t dma_data,
  output logic                dma_valid,
  output logic                dma_last,
  input  logic                dma_ready,
  output logic                overflow
);

  import rx_pkg::*;

  localparam int AW = $clog2(`RX_BUF_DEPTH);

  kept_frame_t mem [`RX_BUF_DEPTH]; // frame storage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;             // 0 to depth
  logic          full;
  logic          empty;
  logic          wr_en;
  logic          pop;               // last record of head accepted
  kept_frame_t   head;
  chan_mask_t    sent_q;            // head channels already sent
  chan_mask_t    remain;
  chan_idx_t     cur_ch;

  assign full   = (count == (AW+1)'(`RX_BUF_DEPTH));
  assign empty  = (count == '0);
  assign wr_en  = kept_valid && !full; // full fifo drops the whole frame
  assign head   = mem[rd_ptr];
  assign remain = head.mask & ~sent_q;

  ////////////////////////////////////////////////////////////
  // serializer
  ////////////////////////////////////////////////////////////
  always_comb begin
    cur_ch = '0;
    // lowest unsent channel wins
    for (int c = `RX_CHANNELS-1; c >= 0; c--) begin
      if (remain[c]) cur_ch = chan_idx_t'(c);
    end
  end

  assign dma_valid        = !empty;
  assign dma_last         = dma_valid && ((remain & ~(chan_mask_t'(1) << cur_ch)) == '0);
  assign pop              = dma_valid && dma_ready && dma_last;
  assign dma_data.chan    = cur_ch;
  assign dma_data.tstamp  = head.tstamp;
  assign dma_data.samples = head.data[cur_ch];

  ////////////////////////////////////////////////////////////
  // fifo control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      sent_q   <= '0;
      overflow <= 1'b0;
    end else begin
      if (kept_valid && full) overflow <= 1'b1; // sticky until reset
      if (wr_en) wr_ptr <= (wr_ptr == AW'(`RX_BUF_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == AW'(`RX_BUF_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (dma_valid && dma_ready) begin
        sent_q <= dma_last ? '0 : (sent_q | (chan_mask_t'(1) << cur_ch));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= kept;
  end

  // dropped frame leaves the write side untouched
  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
    (kept_valid && full) |=> (wr_ptr == $past(wr_ptr)));

  // record held steady under back-pressure
  a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (dma_valid && !dma_ready) |=> (dma_valid && $stable(dma_data) && $stable(dma_last)));

  // upstream never stores an empty mask, so every record has its bit set
  a_mask_bit: assert property (@(posedge clk) disable iff (!arst_n)
    dma_valid |-> head.mask[cur_ch]);

endmodule

//--- src/receive_top.sv
// receive chain top level
// differentiator, channel mux, discriminator and sample buffer in series
`timescale 1ns/1ps

module receive_top (
  input  logic                clk,
  input  logic                arst_n,
  // adc frames, realtime
  input  rx_pkg::adc_frame_t  adc_data,
  input  logic                adc_valid,
  // configuration, realtime
  input  rx_pkg::mux_cfg_t    mux_cfg,
  input  logic                mux_cfg_valid,
  input  rx_pkg::disc_cfg_t   disc_cfg,
  input  logic                disc_cfg_valid,
  // dma record stream
  output rx_pkg::dma_record_t dma_data,
  output logic                dma_valid,
  output logic                dma_last,
  input  logic                dma_ready,
  output logic                overflow
);

  import rx_pkg::*;

  src_frame_t  src_data;   // raw and differentiated sources
  logic        src_valid;
  adc_frame_t  log_data;   // logical channels
  logic        log_valid;
  kept_frame_t kept;       // frames worth storing
  logic        kept_valid;

  ////////////////////////////////////////////////////////////
  // source generation and selection
  ////////////////////////////////////////////////////////////
  axis_differentiator differentiator_i (
    .clk,
    .arst_n,
    .adc_data,
    .adc_valid,
    .src_data,
    .src_valid
  );

  axis_channel_mux channel_mux_i (
    .clk,
    .arst_n,
    .src_data,
    .src_valid,
    .mux_cfg,
    .mux_cfg_valid,
    .log_data,
    .log_valid
  );

  ////////////////////////////////////////////////////////////
  // selection of frames and storage
  ////////////////////////////////////////////////////////////
  sample_discriminator discriminator_i (
    .clk,
    .arst_n,
    .log_data,
    .log_valid,
    .disc_cfg,
    .disc_cfg_valid,
    .kept,
    .kept_valid
  );

  sample_buffer buffer_i (
    .clk,
    .arst_n,
    .kept,
    .kept_valid,
    .dma_data,
    .dma_valid,
    .dma_last,
    .dma_ready,
    .overflow
  );

endmodule

//--- tb/receive_top_tb.sv
// receive chain testbench
// random and ramp frames through the whole chain with dma records checked against a model
`timescale 1ns/1ps
`include "rx_consts.svh"

module receive_top_tb;

  import rx_pkg::*;

  localparam int      MAX_CYCLES   = 4000; // sequence needs about 1500
  localparam int      DRAIN_CYCLES = 200;  // full fifo drains well within this
  localparam int      READY_LOW    = 0;
  localparam int      READY_RAND   = 1;
  localparam int      READY_HIGH   = 2;
  localparam sample_t S_MIN        = 16'sh8000;
  localparam sample_t S_MAX        = 16'sh7fff;

  typedef struct packed {
    dma_record_t rec;
    logic        last;
  } exp_rec_t;

  logic        clk = 1'b0;
  logic        arst_n;
  adc_frame_t  adc_data;
  logic        adc_valid;
  mux_cfg_t    mux_cfg;
  logic        mux_cfg_valid;
  disc_cfg_t   disc_cfg;
  logic        disc_cfg_valid;
  dma_record_t dma_data;
  logic        dma_valid;
  logic        dma_last;
  logic        dma_ready = 1'b0;
  logic        overflow;

  // reference model state
  sample_t     ref_prev [`RX_CHANNELS]; // last raw sample seen per channel
  mux_cfg_t    ref_mux;
  disc_cfg_t   ref_disc;
  disc_state_t ref_state [`RX_CHANNELS];
  tstamp_t     ref_count;               // frames seen so far
  int          ref_held;                // frames stored or on their way
  exp_rec_t    exp_q [$];

  integer      seed = 65;
  int          ready_mode = READY_LOW;
  int          cycles = 0;
  logic        stalled = 1'b0;          // last negedge saw valid without ready
  dma_record_t held_data;
  logic        held_last;
  exp_rec_t    exp_now;

  always #2 clk = ~clk;

  receive_top receive_top_i (.*);

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic string mismatch_text(input string sig, input logic [127:0] exp_v,
                                          input logic [127:0] got_v);
    return $sformatf("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, got_v);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model called once per driven frame
  ////////////////////////////////////////////////////////////
  function automatic void model_frame(input adc_frame_t f);
    sample_t    hist [`RX_PAR_SAMPLES+1]; // previous last sample followed by this frame
    src_frame_t src;
    adc_frame_t lg;
    chan_mask_t mask;
    logic       above;
    logic       below;
    int         last_ch;
    tstamp_t    stamp;
    exp_rec_t   e;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      hist[0] = ref_prev[c];
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) hist[k+1] = f[c][k];
      src[c] = f[c];
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) src[`RX_CHANNELS+c][k] = hist[k+1] - hist[k];
      ref_prev[c] = hist[`RX_PAR_SAMPLES];
    end
    mask = '0;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      lg[c] = src[ref_mux[c]];
      above = 1'b0;
      below = 1'b1;
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) begin
        if ($signed(lg[c][k]) > $signed(ref_disc.high[c])) above = 1'b1;
        if ($signed(lg[c][k]) >= $signed(ref_disc.low[c])) below = 1'b0;
      end
      if (ref_state[c] == ACTIVE) begin
        mask[c] = 1'b1;                       // stays kept through the closing frame
        if (below) ref_state[c] = IDLE;
      end else if (above) begin
        mask[c] = 1'b1;
        ref_state[c] = ACTIVE;
      end
    end
    stamp = ref_count;
    ref_count = ref_count + 1;
    if (mask == '0 || ref_held >= `RX_BUF_DEPTH) return; // nothing kept or fifo full
    ref_held++;
    last_ch = 0;
    for (int c = 0; c < `RX_CHANNELS; c++) if (mask[c]) last_ch = c;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if (mask[c]) begin
        e.rec.chan    = chan_idx_t'(c);
        e.rec.tstamp  = stamp;
        e.rec.samples = lg[c];
        e.last        = (c == last_ch);
        exp_q.push_back(e);
      end
    end
  endfunction

  function automatic adc_frame_t random_frame(input int amp); // amp 0 means full range
    adc_frame_t f;
    int         r;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) begin
        r = $random(seed);
        f[c][k] = (amp == 0) ? sample_t'(r) : sample_t'(r % amp);
      end
    end
    return f;
  endfunction

  function automatic adc_frame_t ramp_frame(input int n);
    adc_frame_t f;
    int         pos;
    int         r;
    for (int k = 0; k < `RX_PAR_SAMPLES; k++) begin
      pos = (n * `RX_PAR_SAMPLES + k) % 80;
      f[0][k] = sample_t'(((pos < 40) ? pos : 80 - pos) * 100 - 2000); // triangle of +-2000
      r = $random(seed);
      f[1][k] = sample_t'(r % 3000);
    end
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers called 1 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_frame(input adc_frame_t f, input bit throttle);
    while (throttle && ref_held >= `RX_BUF_DEPTH) next_cycle(); // never let the fifo fill
    adc_data  = f;
    adc_valid = 1'b1;
    model_frame(f);
    next_cycle();
    adc_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) next_cycle();
    repeat (8) next_cycle(); // pipeline idle before any config change
  endtask

  // bounded wait for the expected queue to empty
  task automatic drain_records(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      next_cycle();
      n++;
    end
  endtask

  task automatic set_mux(input src_idx_t s0, input src_idx_t s1);
    mux_cfg[0]    = s0;
    mux_cfg[1]    = s1;
    mux_cfg_valid = 1'b1;
    ref_mux       = mux_cfg;
    next_cycle();
    mux_cfg_valid = 1'b0;
  endtask

  task automatic set_thresholds(input sample_t h0, input sample_t l0,
                                input sample_t h1, input sample_t l1);
    disc_cfg.high[0] = h0;
    disc_cfg.low[0]  = l0;
    disc_cfg.high[1] = h1;
    disc_cfg.low[1]  = l1;
    disc_cfg_valid   = 1'b1;
    ref_disc         = disc_cfg;
    next_cycle();
    disc_cfg_valid   = 1'b0;
  endtask

  always @(posedge clk) begin
    #1;
    case (ready_mode)
      READY_HIGH: dma_ready = 1'b1;
      READY_RAND: dma_ready = ($random(seed) % 2) != 0; // about half the cycles
      default:    dma_ready = 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_with_error($sformatf("timeout, no end after %0d cycles", cycles));
    end
  end

  ////////////////////////////////////////////////////////////
  // scoreboard sampled at the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!arst_n) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        assert (dma_valid) else stop_with_error("dma_valid dropped before its record was taken");
        assert (dma_data == held_data)
          else stop_with_error(mismatch_text("dma_data", 128'(held_data), 128'(dma_data)));
        assert (dma_last == held_last)
          else stop_with_error(mismatch_text("dma_last", 128'(held_last), 128'(dma_last)));
      end
      if (dma_valid && dma_ready) begin
        assert (exp_q.size() != 0)
          else stop_with_error("a record came out that was not expected");
        exp_now = exp_q.pop_front();
        assert (dma_data.chan == exp_now.rec.chan) else stop_with_error(
          mismatch_text("dma_data.chan", 128'(exp_now.rec.chan), 128'(dma_data.chan)));
        assert (dma_data.tstamp == exp_now.rec.tstamp) else stop_with_error(
          mismatch_text("dma_data.tstamp", 128'(exp_now.rec.tstamp), 128'(dma_data.tstamp)));
        assert (dma_data.samples == exp_now.rec.samples) else stop_with_error(
          mismatch_text("dma_data.samples", 128'(exp_now.rec.samples), 128'(dma_data.samples)));
        assert (dma_last == exp_now.last)
          else stop_with_error(mismatch_text("dma_last", 128'(exp_now.last), 128'(dma_last)));
        if (exp_now.last) ref_held--; // head frame popped
      end
      stalled   = dma_valid && !dma_ready;
      held_data = dma_data;
      held_last = dma_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    arst_n = 1'b0;
    adc_data = '0;
    adc_valid = 1'b0;
    mux_cfg = '0;
    mux_cfg_valid = 1'b0;
    disc_cfg = '0;
    disc_cfg_valid = 1'b0;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      ref_prev[c]  = '0;
      ref_mux[c]   = src_idx_t'(c); // identity after reset
      ref_state[c] = IDLE;
    end
    ref_disc  = '0;
    ref_count = '0;
    ref_held  = 0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // outputs stay quiet after reset without adc traffic
    ready_mode = READY_HIGH;
    assert (!dma_valid && !dma_last && !overflow)
      else stop_with_error(mismatch_text("dma_valid/dma_last/overflow", 128'(0),
                                         128'({dma_valid, dma_last, overflow})));
    repeat (20) begin
      next_cycle();
      assert (!dma_valid)
        else stop_with_error(mismatch_text("dma_valid", 128'(0), 128'(dma_valid)));
    end

    // raw pass-through with every frame kept
    set_thresholds(S_MIN, S_MIN, S_MIN, S_MIN);
    repeat (40) send_frame(random_frame(0), 1'b1);
    wait_drained();

    // difference sources with logical 0 cross-mapped to physical 1
    set_mux(2'd3, 2'd2);
    repeat (40) send_frame(random_frame(0), 1'b1);
    wait_drained();

    // hysteresis test closes out the active channels first
    set_thresholds(S_MAX, S_MAX, S_MAX, S_MAX);
    send_frame('0, 1'b1);
    wait_drained();
    set_mux(2'd0, 2'd1);
    wait_drained();
    set_thresholds(16'sd1500, -16'sd1500, 16'sd2500, 16'sd0);
    for (int n = 0; n < 60; n++) send_frame(ramp_frame(n), 1'b1);
    repeat (60) send_frame(random_frame(3000), 1'b1);
    wait_drained();

    // back-pressure with ready about half the time
    ready_mode = READY_RAND;
    set_mux(2'd0, 2'd3);
    wait_drained();
    set_thresholds(16'sd0, -16'sd500, 16'sd0, -16'sd500);
    repeat (150) send_frame(random_frame(0), 1'b1);
    wait_drained();

    // overflow as the fifo fills while ready is held low
    assert (!overflow) else stop_with_error(mismatch_text("overflow", 128'(0), 128'(overflow)));
    ready_mode = READY_LOW;
    set_thresholds(S_MIN, S_MIN, S_MIN, S_MIN);
    repeat (`RX_BUF_DEPTH + 4) send_frame(random_frame(0), 1'b0);
    repeat (10) next_cycle();
    assert (overflow) else stop_with_error(mismatch_text("overflow", 128'(1), 128'(overflow)));
    ready_mode = READY_HIGH;
    drain_records(DRAIN_CYCLES);
    repeat (8) next_cycle(); // a stray record after the last expected one is caught here

    if (exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_error($sformatf("%0d expected records never came out", exp_q.size()));
    end
  end

endmodule

//--- rx_chain.f
+incdir+src
src/rx_pkg.sv
src/axis_differentiator.sv
src/axis_channel_mux.sv
src/sample_discriminator.sv
src/sample_buffer.sv
src/receive_top.sv
tb/receive_top_tb.sv

//--- build.sh
#!/bin/sh
# compile the receive chain testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module receive_top_tb -f rx_chain.f -o receive_top_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/receive_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0
